//--- figaro.f
+incdir+hw
hw/figaro_bus_pkg.sv
hw/figaro_core_pkg.sv
hw/figaro_api.sv
hw/figaro_sampler.sv
hw/figaro_collector.sv
hw/figaro.sv
test/tb_clock.sv
test/figaro_chk.sv
test/figaro_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = figaro_tb
FILELIST  = figaro.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/figaro_tb.sv
// --------------------
// Figaro testbench
// Table-driven rate and noise rows over the register bus
// --------------------

`include "figaro_config.svh"

module figaro_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD_NS = 40;
  localparam int DRIVE_DELAY   = 2;
  localparam int NUM_ROWS      = 9;
  localparam int NOISE_ZERO    = 0;
  localparam int NOISE_ONE     = 1;
  localparam int NOISE_RAND    = 2;
  localparam longint WATCHDOG_MARGIN_NS = 20000;
  localparam figaro_bus_pkg::data_t STATUS_READY = 32'h1 << `FIGARO_STATUS_READY_BIT;

  logic clk;
  logic arst_n;
  logic cs;
  logic we;
  logic noise;
  logic ready;
  figaro_bus_pkg::addr_t address;
  figaro_bus_pkg::data_t write_data;
  figaro_bus_pkg::data_t read_data;
  figaro_bus_pkg::data_t word;

  int     errors = 0;
  int     checks = 0;
  int     noise_mode;
  int     mode_now;
  integer seed = 94880;
  integer rnd;

  // --------------------
  // Stimulus table
  // --------------------
  // Odd rate with noise 1 gives ones, even rate or noise 0 gives zeros
  int rate_tab [NUM_ROWS] = '{3, 5, 2, 4, 3, 0, 1, 7, 2};
  int mode_tab [NUM_ROWS] = '{NOISE_ONE, NOISE_ONE, NOISE_ONE, NOISE_ONE, NOISE_ZERO,
                              NOISE_ONE, NOISE_ZERO, NOISE_RAND, NOISE_RAND};
  figaro_bus_pkg::data_t exp_tab [NUM_ROWS] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0,
                                                32'h0, 32'hFFFF_FFFF, 32'h0, 32'h0, 32'h0};
  // Random rows have no expected word
  bit check_tab [NUM_ROWS] = '{1, 1, 1, 1, 1, 1, 1, 0, 0};
  // Rows that leave the full word unread for a while
  bit hold_tab  [NUM_ROWS] = '{1, 0, 0, 0, 0, 0, 1, 0, 0};

  tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock_i (.clk(clk));

  figaro figaro_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .ready      (ready),
    .noise      (noise)
  );

  // Noise driver, mode taken at the edge
  always begin
    @(posedge clk);
    mode_now = noise_mode;
    #DRIVE_DELAY;
    case (mode_now)
      NOISE_ONE:  noise = 1'b1;
      NOISE_RAND: begin
        rnd   = $random(seed);
        noise = rnd[0];
      end
      default:    noise = 1'b0;
    endcase
  end

  // --------------------
  // Checks and bus tasks
  // --------------------
  task automatic check_word(input string what, input figaro_bus_pkg::data_t got,
                            input figaro_bus_pkg::data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Tasks start and end DRIVE_DELAY after a rising edge
  task automatic bus_write(input figaro_bus_pkg::addr_t addr, input figaro_bus_pkg::data_t data);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(negedge clk);
    check_word("ready during write", {31'b0, ready}, 32'h1);
    check_word("read data during write", read_data, '0);
    @(posedge clk);
    #DRIVE_DELAY;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
  endtask

  task automatic bus_read(input figaro_bus_pkg::addr_t addr, output figaro_bus_pkg::data_t data);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    @(negedge clk);
    data = read_data;
    check_word("ready during read", {31'b0, ready}, 32'h1);
    @(posedge clk);
    #DRIVE_DELAY;
    cs      = 1'b0;
    address = '0;
  endtask

  task automatic idle_check();
    @(negedge clk);
    check_word("read data with cs low", read_data, '0);
    check_word("ready with cs low", {31'b0, ready}, '0);
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Poll status, watchdog bounds the wait
  task automatic wait_word_ready();
    figaro_bus_pkg::data_t status;
    do begin
      bus_read(`FIGARO_ADDR_STATUS, status);
    end while (status[`FIGARO_STATUS_READY_BIT] !== 1'b1);
  endtask

  // Back-pressure and read-only register writes
  task automatic hold_full_word(input int mode, input int rate);
    figaro_bus_pkg::data_t status;
    int eff;
    eff = (rate == 0) ? 1 : rate;
    // Opposite noise would show up if the word were overwritten
    noise_mode = (mode == NOISE_ONE) ? NOISE_ZERO : NOISE_ONE;
    bus_write(`FIGARO_ADDR_STATUS, 32'hFFFF_FFFF);
    bus_write(`FIGARO_ADDR_ENTROPY, 32'hFFFF_FFFF);
    repeat ((`FIGARO_WORD_BITS + 1) * eff) @(posedge clk);
    #DRIVE_DELAY;
    bus_read(`FIGARO_ADDR_STATUS, status);
    check_word("status while word held", status, STATUS_READY);
    bus_read(8'h44, status);
    check_word("unmapped address read", status, '0);
  endtask

  // Flush, checked word and hold, each up to one word time
  function automatic longint watchdog_limit_ns();
    longint total;
    int eff;
    total = WATCHDOG_MARGIN_NS;
    for (int r = 0; r < NUM_ROWS; r++) begin
      eff   = (rate_tab[r] == 0) ? 1 : rate_tab[r];
      total += 3 * longint'(eff) * `FIGARO_WORD_BITS * CLK_PERIOD_NS;
    end
    return total;
  endfunction

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    #(watchdog_limit_ns());
    $display("Timeout: no entropy word arrived in time, run stopped at %0t", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    noise      = 1'b0;
    noise_mode = NOISE_ZERO;
    arst_n     = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    // Reset state of the register front end
    idle_check();
    bus_read(`FIGARO_ADDR_STATUS, word);
    check_word("status after reset", word, '0);
    bus_read(8'h00, word);
    check_word("unmapped address read", word, '0);

    for (int row = 0; row < NUM_ROWS; row++) begin
      idle_check();
      noise_mode = mode_tab[row];
      bus_write(`FIGARO_ADDR_SAMPLE_RATE, figaro_bus_pkg::data_t'(rate_tab[row]));
      // First word may hold bits from the previous setting
      wait_word_ready();
      bus_read(`FIGARO_ADDR_ENTROPY, word);
      wait_word_ready();
      if (hold_tab[row]) begin
        hold_full_word(mode_tab[row], rate_tab[row]);
      end
      bus_read(`FIGARO_ADDR_ENTROPY, word);
      if (check_tab[row]) begin
        check_word($sformatf("entropy word, row %0d", row), word, exp_tab[row]);
      end
      // One read consumes exactly one word
      bus_read(`FIGARO_ADDR_STATUS, word);
      check_word("status after entropy read", word, '0);
    end

    $display("Done: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, figaro_i.chk_i.fail_count);
    if (errors == 0 && figaro_i.chk_i.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- test/figaro_chk.sv
// --------------------
// Figaro collector and decode assertions
// --------------------

module figaro_chk (
  input  logic                          clk,
  input  logic                          arst_n,
  input  figaro_core_pkg::entropy_t     entropy,
  input  logic                          entropy_ready,
  input  logic                          read_entropy,
  input  logic                          set_sample_rate,
  input  figaro_core_pkg::sample_rate_t sample_rate,
  input  logic                          sample_strobe
);

  timeunit 1ns;
  timeprecision 100ps;

  // Assertion failures so far
  int fail_count = 0;

  // A new word is only flagged right after a sample arrives
  ready_after_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(entropy_ready) |-> $past(sample_strobe))
    else begin
      $error("entropy_ready rose without a sample strobe");
      fail_count++;
    end

  // Held word must survive until it is read
  held_word_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (entropy_ready && !read_entropy) |=> $stable(entropy))
    else begin
      $error("entropy changed while a word was held");
      fail_count++;
    end

  // Rate write restarts the interval, no strobe right after it
  rate_write_restarts: assert property (@(posedge clk) disable iff (!arst_n)
    (set_sample_rate && sample_rate != figaro_core_pkg::sample_rate_t'(1))
      |=> !sample_strobe)
    else begin
      $error("sample strobe right after a rate write");
      fail_count++;
    end

endmodule

// Bound at the top so decode and collector signals are both visible
bind figaro figaro_chk chk_i (
  .clk             (clk),
  .arst_n          (arst_n),
  .entropy         (entropy),
  .entropy_ready   (entropy_ready),
  .read_entropy    (read_entropy),
  .set_sample_rate (set_sample_rate),
  .sample_rate     (sample_rate),
  .sample_strobe   (sample_strobe)
);

//--- test/tb_clock.sv
// --------------------
// Testbench clock source
// --------------------

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free-running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

//--- hw/figaro.sv
// --------------------
// Figaro entropy source top
// --------------------

module figaro (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cs,
  input  logic                  we,
  input  figaro_bus_pkg::addr_t address,
  input  figaro_bus_pkg::data_t write_data,
  output figaro_bus_pkg::data_t read_data,
  output logic                  ready,
  input  logic                  noise
);

  // Decode to sampler
  logic                          set_sample_rate;
  figaro_core_pkg::sample_rate_t sample_rate;
  // Sampler to collector
  logic                          sample_strobe;
  logic                          sample_bit;
  // Collector and decode
  figaro_core_pkg::entropy_t     entropy;
  logic                          entropy_ready;
  logic                          read_entropy;

  // --------------------
  // Register front end
  // --------------------
  figaro_api api_i (
    .cs              (cs),
    .we              (we),
    .address         (address),
    .write_data      (write_data),
    .entropy         (entropy),
    .entropy_ready   (entropy_ready),
    .set_sample_rate (set_sample_rate),
    .sample_rate     (sample_rate),
    .read_entropy    (read_entropy),
    .read_data       (read_data),
    .ready           (ready)
  );

  // --------------------
  // Core
  // --------------------
  figaro_sampler sampler_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .set_sample_rate (set_sample_rate),
    .sample_rate     (sample_rate),
    .noise           (noise),
    .sample_strobe   (sample_strobe),
    .sample_bit      (sample_bit)
  );

  figaro_collector collector_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .sample_strobe (sample_strobe),
    .sample_bit    (sample_bit),
    .read_entropy  (read_entropy),
    .entropy       (entropy),
    .entropy_ready (entropy_ready)
  );

endmodule

//--- hw/figaro_collector.sv
// --------------------
// Figaro word collector
// Packs sampled bits into words, holds each until read
// --------------------

`include "figaro_config.svh"

module figaro_collector (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       sample_strobe,
  input  logic                       sample_bit,
  input  logic                       read_entropy,
  output figaro_core_pkg::entropy_t  entropy,
  output logic                       entropy_ready
);

  figaro_core_pkg::collect_state_t state;
  // Samples in the word being built
  figaro_core_pkg::bit_count_t     bit_count;
  // Word under construction
  figaro_core_pkg::entropy_t       shift_reg;
  figaro_core_pkg::entropy_t       shift_next;
  // Accept a sample this cycle
  logic                            shift_en;
  // This sample completes the word
  logic                            word_done;

  // --------------------
  // Datapath
  // --------------------
  // New bit enters at the LSB
  assign shift_next = {shift_reg[`FIGARO_WORD_BITS-2:0], sample_bit};

  // Strobes in FULL are dropped so an unread word survives
  assign shift_en  = sample_strobe && (state == figaro_core_pkg::COLLECT) && !read_entropy;
  assign word_done =
    shift_en && (bit_count == figaro_core_pkg::bit_count_t'(`FIGARO_WORD_BITS - 1));

  always_ff @(posedge clk) begin
    if (shift_en) begin
      shift_reg <= shift_next;
    end
  end

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= figaro_core_pkg::COLLECT;
      bit_count     <= '0;
      entropy       <= '0;
      entropy_ready <= 1'b0;
    end else if (read_entropy) begin
      // Word consumed, start over
      state         <= figaro_core_pkg::COLLECT;
      bit_count     <= '0;
      entropy_ready <= 1'b0;
    end else if (word_done) begin
      entropy       <= shift_next;
      entropy_ready <= 1'b1;
      state         <= figaro_core_pkg::FULL;
      bit_count     <= '0;
    end else if (shift_en) begin
      bit_count <= bit_count + 1'b1;
    end
  end

endmodule

//--- hw/figaro_sampler.sv
// --------------------
// Figaro noise sampler
// Folds the noise bit into parity and emits one bit per interval
// --------------------

`include "figaro_config.svh"

module figaro_sampler (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          set_sample_rate,
  input  figaro_core_pkg::sample_rate_t sample_rate,
  input  logic                          noise,
  output logic                          sample_strobe,
  output logic                          sample_bit
);

  // Interval length in cycles
  figaro_core_pkg::sample_rate_t rate_reg;
  // Cycles left in the current interval, minus one
  figaro_core_pkg::sample_rate_t count;
  // Running parity of noise in this interval
  logic                          parity;
  // Parity including the current cycle's noise
  logic                          parity_next;

  // --------------------
  // Strobe and sample
  // --------------------
  assign parity_next   = parity ^ noise;
  // Last cycle of the interval
  assign sample_strobe = (count == '0);
  assign sample_bit    = parity_next;

  // --------------------
  // Rate, counter, parity
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rate_reg <= figaro_core_pkg::sample_rate_t'(`FIGARO_DEFAULT_SAMPLE_RATE);
      count    <= figaro_core_pkg::sample_rate_t'(`FIGARO_DEFAULT_SAMPLE_RATE - 1);
      parity   <= 1'b0;
    end else if (set_sample_rate) begin
      // New rate restarts the interval
      rate_reg <= sample_rate;
      count    <= sample_rate - 1'b1;
      parity   <= 1'b0;
    end else if (sample_strobe) begin
      // Interval done, reload and start a fresh parity
      count  <= rate_reg - 1'b1;
      parity <= 1'b0;
    end else begin
      count  <= count - 1'b1;
      parity <= parity_next;
    end
  end

endmodule

//--- hw/figaro_api.sv
// --------------------
// Figaro register decode
// Turns bus accesses into core commands and read data
// --------------------

`include "figaro_config.svh"

module figaro_api (
  input  logic                         cs,
  input  logic                         we,
  input  figaro_bus_pkg::addr_t        address,
  input  figaro_bus_pkg::data_t        write_data,
  input  figaro_core_pkg::entropy_t    entropy,
  input  logic                         entropy_ready,
  output logic                         set_sample_rate,
  output figaro_core_pkg::sample_rate_t sample_rate,
  output logic                         read_entropy,
  output figaro_bus_pkg::data_t        read_data,
  output logic                         ready
);

  // Raw rate from the low bits of write data
  figaro_core_pkg::sample_rate_t rate_raw;
  // Status register contents
  figaro_bus_pkg::data_t         status_word;

  // --------------------
  // Write data path
  // --------------------
  assign rate_raw = write_data[$bits(figaro_core_pkg::sample_rate_t)-1:0];

  // Zero rate would stall the sampler, store it as one
  assign sample_rate = (rate_raw == '0) ? figaro_core_pkg::sample_rate_t'(1) : rate_raw;

  // No wait states, ready simply follows cs
  assign ready = cs;

  always_comb begin
    status_word = '0;
    status_word[`FIGARO_STATUS_READY_BIT] = entropy_ready;
  end

  // --------------------
  // Command decode
  // --------------------
  always_comb begin
    set_sample_rate = 1'b0;
    read_entropy    = 1'b0;
    read_data       = '0;

    if (cs) begin
      if (we) begin
        // Only the rate register is writable
        if (address == `FIGARO_ADDR_SAMPLE_RATE) begin
          set_sample_rate = 1'b1;
        end
      end else begin
        if (address == `FIGARO_ADDR_STATUS) begin
          read_data = status_word;
        end else if (address == `FIGARO_ADDR_ENTROPY) begin
          // Reading the word consumes it
          read_data    = figaro_bus_pkg::data_t'(entropy);
          read_entropy = 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/figaro_core_pkg.sv
// --------------------
// Figaro entropy core types
// --------------------

`include "figaro_config.svh"

package figaro_core_pkg;

  // --------------------
  // Sampler
  // --------------------
  // Clock cycles per sample, low 24 bits of write data
  typedef logic [23:0] sample_rate_t;

  // --------------------
  // Collector
  // --------------------
  // One packed entropy word
  typedef logic [`FIGARO_WORD_BITS-1:0] entropy_t;

  // Samples gathered so far, wide enough for a full word
  typedef logic [5:0] bit_count_t;

  // Collector FSM
  typedef enum logic {
    COLLECT,
    FULL
  } collect_state_t;

endpackage

//--- hw/figaro_bus_pkg.sv
// --------------------
// Figaro register bus types
// --------------------

package figaro_bus_pkg;

  // --------------------
  // Address side
  // --------------------
  // Byte-wide register address
  typedef logic [7:0] addr_t;

  // --------------------
  // Data side
  // --------------------
  // Read and write data word
  typedef logic [31:0] data_t;

  // Both bus directions use data_t
  // Status and entropy words are widened to it

endpackage

//--- hw/figaro_config.svh
// --------------------
// Figaro register map and sizing
// --------------------

`ifndef FIGARO_CONFIG_SVH
`define FIGARO_CONFIG_SVH

// --------------------
// Register addresses
// --------------------
`define FIGARO_ADDR_STATUS      8'h09
`define FIGARO_ADDR_SAMPLE_RATE 8'h10
`define FIGARO_ADDR_ENTROPY     8'h20

// Ready flag position in status word
`define FIGARO_STATUS_READY_BIT 0

// --------------------
// Core sizing
// --------------------
// Cycles per sample after reset
`define FIGARO_DEFAULT_SAMPLE_RATE 16
// Samples packed into one entropy word
`define FIGARO_WORD_BITS 32

`endif
